// ==== common/resize_pkg.sv ====
// shared constants for the stream width converter
// default input width and ratios, plus width helper functions

package resize_pkg;

  // default narrow input width in bits
  localparam int DWIDTH_IN_DEFAULT = 24;

  // default upsize and downsize ratios
  localparam int UP_DEFAULT = 4;
  localparam int DOWN_DEFAULT = 3;

  // width of a counter that indexes slots 0 .. ratio-1
  // never less than one bit so a ratio of 1 still gets a legal vector
  function automatic int count_width(input int ratio);
    int w;
    if (ratio > 1) begin
      w = $clog2(ratio);
    end else begin
      w = 1;
    end
    return w;
  endfunction

  // output width of the converter
  // input width is first multiplied by UP, then split into DOWN slices
  function automatic int conv_out_width(
    input int dwidth_in,
    input int up,
    input int down
  );
    int w;
    w = (dwidth_in * up) / down;
    return w;
  endfunction

endpackage

// ==== width_converter/axis_upsizer.sv ====
// stream upsizer with valid, ready and last
// packs UP narrow input words into one wide output word
// a partial word is flushed early with zero padding when last arrives
`timescale 1ns/1ns

module axis_upsizer #(
  parameter int DWIDTH = 24,
  parameter int UP = 4
) (
  input  logic                     clk,
  input  logic                     reset,

  // narrow input stream
  input  logic [DWIDTH-1:0]        in_data,
  input  logic                     in_valid,
  output logic                     in_ready,
  input  logic                     in_last,

  // wide output stream
  output logic [DWIDTH*UP-1:0]     out_data,
  output logic                     out_valid,
  input  logic                     out_ready,
  output logic                     out_last
);

  import resize_pkg::*;

  localparam int CW = count_width(UP);
  localparam int OWIDTH = DWIDTH * UP;

  // index of the final slot of a wide word
  localparam logic [CW-1:0] LAST_SLOT = CW'(UP - 1);

  // fill counter pointing at the next free slot
  logic [CW-1:0]     cnt;

  // word under assembly and its value after this cycle's write
  logic [OWIDTH-1:0] asm_data;
  logic [OWIDTH-1:0] asm_next;

  logic              in_accept;
  logic              out_take;
  logic              slot_full;
  logic              flush;

  // output register is free, or its word leaves this cycle
  assign in_ready = !out_valid || out_ready;

  assign in_accept = in_valid && in_ready;
  assign out_take = out_valid && out_ready;

  // the incoming word lands in the final slot
  assign slot_full = (cnt == LAST_SLOT);

  // hand the assembled word over on a full word or at packet end
  assign flush = in_accept && (slot_full || in_last);

  // slot write
  // starting a new word clears every upper slot, which gives the
  // zero padding of a partial word
  always_comb begin
    if (cnt == '0) begin
      asm_next = '0;
    end else begin
      asm_next = asm_data;
    end
    asm_next[cnt*DWIDTH +: DWIDTH] = in_data;
  end

  // fill counter
  always_ff @(posedge clk) begin
    if (reset) begin
      cnt <= '0;
    end else if (in_accept) begin
      if (flush) begin
        cnt <= '0;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  // output handshake state
  // a new word may arrive in the same cycle as the old one leaves
  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
      out_last <= 1'b0;
    end else begin
      if (flush) begin
        out_valid <= 1'b1;
        out_last <= in_last;
      end else if (out_take) begin
        out_valid <= 1'b0;
        out_last <= 1'b0;
      end
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (in_accept) begin
      asm_data <= asm_next;
    end
    // assembled word moves to the output one cycle after its final input
    if (flush) begin
      out_data <= asm_next;
    end
  end

endmodule

// ==== width_converter/axis_downsizer.sv ====
// stream downsizer with valid, ready and last
// splits each wide input word into DOWN narrow slices, lowest slice first
// last goes out only with the final slice of a word that carried it
`timescale 1ns/1ns

module axis_downsizer #(
  parameter int DWIDTH = 96,
  parameter int DOWN = 3
) (
  input  logic                     clk,
  input  logic                     reset,

  // wide input stream
  input  logic [DWIDTH-1:0]        in_data,
  input  logic                     in_valid,
  output logic                     in_ready,
  input  logic                     in_last,

  // narrow output stream
  output logic [DWIDTH/DOWN-1:0]   out_data,
  output logic                     out_valid,
  input  logic                     out_ready,
  output logic                     out_last
);

  import resize_pkg::*;

  localparam int CW = count_width(DOWN);
  localparam int SW = DWIDTH / DOWN;

  // index of the highest slice
  localparam logic [CW-1:0] LAST_IDX = CW'(DOWN - 1);

  // current wide word and the last flag that came with it
  logic [DWIDTH-1:0] word_data;
  logic              word_last;

  // slice index that selects the output slice
  logic [CW-1:0]     idx;

  logic              final_slice;
  logic              out_take;
  logic              in_accept;

  assign final_slice = (idx == LAST_IDX);
  assign out_take = out_valid && out_ready;

  // load a new word when empty or when the final slice is leaving
  assign in_ready = !out_valid || (out_take && final_slice);
  assign in_accept = in_valid && in_ready;

  // slice select
  assign out_data = word_data[idx*SW +: SW];

  // packet end only on the highest slice
  assign out_last = word_last && final_slice;

  // valid flag and slice index
  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
      idx <= '0;
    end else begin
      if (in_accept) begin
        // fresh word starts with its lowest slice
        out_valid <= 1'b1;
        idx <= '0;
      end else if (out_take) begin
        if (final_slice) begin
          out_valid <= 1'b0;
          idx <= '0;
        end else begin
          idx <= idx + 1'b1;
        end
      end
    end
  end

  // last flag of the held word
  always_ff @(posedge clk) begin
    if (reset) begin
      word_last <= 1'b0;
    end else if (in_accept) begin
      word_last <= in_last;
    end
  end

  // wide word payload
  always_ff @(posedge clk) begin
    if (in_accept) begin
      word_data <= in_data;
    end
  end

endmodule

// ==== width_converter/axis_width_converter.sv ====
// stream width converter, top level
// an upsizer by UP feeding a downsizer by DOWN
// overall ratio is UP:DOWN
// input width times UP must divide by DOWN
`timescale 1ns/1ns

module axis_width_converter #(
  parameter int DWIDTH_IN = resize_pkg::DWIDTH_IN_DEFAULT,
  parameter int UP = resize_pkg::UP_DEFAULT,
  parameter int DOWN = resize_pkg::DOWN_DEFAULT
) (
  input  logic                 clk,
  input  logic                 reset,

  // narrow input stream
  input  logic [DWIDTH_IN-1:0] in_data,
  input  logic                 in_valid,
  output logic                 in_ready,
  input  logic                 in_last,

  // converted output stream
  output logic [resize_pkg::conv_out_width(DWIDTH_IN, UP, DOWN)-1:0] out_data,
  output logic                 out_valid,
  input  logic                 out_ready,
  output logic                 out_last
);

  // width of the wide intermediate stream
  localparam int MID_WIDTH = DWIDTH_IN * UP;

  logic [MID_WIDTH-1:0] mid_data;
  logic                 mid_valid;
  logic                 mid_ready;
  logic                 mid_last;

  // pack UP input words into one wide word
  axis_upsizer #(
    .DWIDTH (DWIDTH_IN),
    .UP     (UP)
  ) u_up (
    .clk       (clk),
    .reset     (reset),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_last   (in_last),
    .out_data  (mid_data),
    .out_valid (mid_valid),
    .out_ready (mid_ready),
    .out_last  (mid_last)
  );

  // split the wide word into DOWN output words
  axis_downsizer #(
    .DWIDTH (MID_WIDTH),
    .DOWN   (DOWN)
  ) u_down (
    .clk       (clk),
    .reset     (reset),
    .in_data   (mid_data),
    .in_valid  (mid_valid),
    .in_ready  (mid_ready),
    .in_last   (mid_last),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_last  (out_last)
  );

endmodule

// ==== dv/axis_width_converter_properties.sv ====
// stream protocol assertions for the width converter
// output held stable under back-pressure, handshake state after reset
// bound to the top level
`timescale 1ns/1ns

module axis_width_converter_properties #(
  parameter int OWIDTH = 32
) (
  input logic              clk,
  input logic              reset,
  input logic              in_ready,
  input logic [OWIDTH-1:0] out_data,
  input logic              out_valid,
  input logic              out_ready,
  input logic              out_last
);

  // a stalled word stays on the bus unchanged
  property p_hold_while_stalled;
    @(posedge clk) disable iff (reset)
      (out_valid && !out_ready) |=> (out_valid && $stable(out_data) && $stable(out_last));
  endproperty

  property p_valid_low_after_reset;
    @(posedge clk) reset |=> !out_valid;
  endproperty

  property p_ready_high_after_reset;
    @(posedge clk) reset |=> in_ready;
  endproperty

  a_hold_while_stalled: assert property (p_hold_while_stalled)
    else $error("output word or last changed while stalled");

  a_valid_low_after_reset: assert property (p_valid_low_after_reset)
    else $error("out_valid high in the cycle after reset");

  a_ready_high_after_reset: assert property (p_ready_high_after_reset)
    else $error("in_ready low in the cycle after reset");

endmodule

bind axis_width_converter axis_width_converter_properties #(
  .OWIDTH (resize_pkg::conv_out_width(DWIDTH_IN, UP, DOWN))
) u_props (
  .clk       (clk),
  .reset     (reset),
  .in_ready  (in_ready),
  .out_data  (out_data),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_last  (out_last)
);

// ==== dv/axis_width_converter_tb.sv ====
// testbench for the stream width converter
// table-driven stimulus, bit-level reference model and scoreboard
// cycle timeout and a closing pass or fail line
`timescale 1ns/1ns

module axis_width_converter_tb;

  import resize_pkg::*;

  localparam int DW_IN = DWIDTH_IN_DEFAULT;
  localparam int UP = UP_DEFAULT;
  localparam int DOWN = DOWN_DEFAULT;
  localparam int DW_OUT = conv_out_width(DW_IN, UP, DOWN);
  localparam int NROWS = 10;
  localparam int HALF = 50;
  // sample point between the falling edge drive and the next rising edge
  localparam int SAMPLE = 25;

  // input gap modes
  localparam int GAP_NONE = 0;
  localparam int GAP_RAND = 1;

  // output ready modes
  localparam int RDY_ALWAYS = 0;
  localparam int RDY_RAND = 1;
  localparam int RDY_HOLD = 2;

  // one stimulus row
  // words is the expected output count per packet
  // a replay row resends the data of the row before it
  typedef struct packed {
    int len;
    int npkt;
    int gap;
    int rdy;
    int replay;
    int words;
  } row_t;

  logic              clk;
  logic              reset;
  logic [DW_IN-1:0]  in_data;
  logic              in_valid;
  logic              in_ready;
  logic              in_last;
  logic [DW_OUT-1:0] out_data;
  logic              out_valid;
  logic              out_ready;
  logic              out_last;

  row_t              rows [NROWS];
  logic [DW_IN-1:0]  stim_data[$];
  logic              stim_last[$];
  logic [DW_IN-1:0]  pkt_words[$];
  logic [DW_OUT-1:0] exp_data[$];
  logic              exp_last[$];
  logic [DW_OUT-1:0] obs_data[$];
  logic              obs_last[$];
  logic [DW_OUT-1:0] prev_obs[$];
  logic [31:0]       data_state;
  logic [31:0]       gap_state;
  logic [31:0]       rdy_state;
  bit                row_done;
  int                errors;
  int                checks;
  int                cycles;
  int                cycle_limit;

  axis_width_converter #(
    .DWIDTH_IN (DW_IN),
    .UP        (UP),
    .DOWN      (DOWN)
  ) dut0 (
    .clk       (clk),
    .reset     (reset),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_last   (in_last),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_last  (out_last)
  );

  always begin
    clk = 1'b0;
    #HALF;
    clk = 1'b1;
    #HALF;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("run timed out after %0d cycles, the DUT stopped delivering words", cycles);
      $display("sim failed");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic note_error(input string msg);
    errors++;
    $display("CHECK FAILED at %0t: %s", $time, msg);
  endtask

  // packet bits in arrival order with zero padding to whole output words
  task automatic model_packet();
    bit                bitq[$];
    int                nout;
    logic [DW_OUT-1:0] w;
    foreach (pkt_words[i]) begin
      for (int b = 0; b < DW_IN; b++) begin
        bitq.push_back(pkt_words[i][b]);
      end
    end
    nout = ((pkt_words.size() + UP - 1) / UP) * DOWN;
    while (bitq.size() < nout * DW_OUT) begin
      bitq.push_back(1'b0);
    end
    for (int k = 0; k < nout; k++) begin
      for (int b = 0; b < DW_OUT; b++) begin
        w[b] = bitq[k * DW_OUT + b];
      end
      exp_data.push_back(w);
      exp_last.push_back(k == nout - 1);
    end
  endtask

  task automatic make_packet(input int len);
    logic [DW_IN-1:0] w;
    pkt_words.delete();
    for (int i = 0; i < len; i++) begin
      data_state = lcg_next(data_state);
      w = DW_IN'(data_state >> 8);
      pkt_words.push_back(w);
      stim_data.push_back(w);
      stim_last.push_back(i == len - 1);
    end
    model_packet();
  endtask

  task automatic send_words(input int gap_mode);
    bit accepted;
    @(negedge clk);
    foreach (stim_data[i]) begin
      if (gap_mode == GAP_RAND) begin
        gap_state = lcg_next(gap_state);
        // zero to three idle cycles before the word
        repeat (gap_state[31:30]) begin
          in_valid = 1'b0;
          @(negedge clk);
        end
      end
      in_valid = 1'b1;
      in_data = stim_data[i];
      in_last = stim_last[i];
      accepted = 1'b0;
      while (!accepted) begin
        #SAMPLE;
        accepted = in_ready;
        @(negedge clk);
      end
    end
    in_valid = 1'b0;
    in_last = 1'b0;
  endtask

  task automatic drive_ready(input int mode);
    int n;
    n = 0;
    while (!row_done) begin
      @(negedge clk);
      case (mode)
        RDY_RAND: begin
          rdy_state = lcg_next(rdy_state);
          out_ready = rdy_state[29];
        end
        RDY_HOLD: out_ready = (n >= 20);
        default: out_ready = 1'b1;
      endcase
      n++;
    end
    out_ready = 1'b1;
  endtask

  task automatic collect_words(input int count);
    while (obs_data.size() < count) begin
      @(negedge clk);
      #SAMPLE;
      if (out_valid && out_ready) begin
        obs_data.push_back(out_data);
        obs_last.push_back(out_last);
      end
    end
    row_done = 1'b1;
  endtask

  task automatic check_row(input int r);
    int run;
    int npk;
    run = 0;
    npk = 0;
    // every observed packet ends after the table's word count
    foreach (obs_last[k]) begin
      run++;
      if (obs_last[k] === 1'b1) begin
        checks++;
        if (run != rows[r].words) begin
          note_error($sformatf("row %0d packet %0d has %0d words, expected %0d",
            r, npk, run, rows[r].words));
        end
        run = 0;
        npk++;
      end
    end
    checks++;
    if (npk != rows[r].npkt) begin
      note_error($sformatf("row %0d shows %0d packet ends, expected %0d",
        r, npk, rows[r].npkt));
    end
    foreach (exp_data[k]) begin
      checks += 2;
      if (obs_data[k] !== exp_data[k]) begin
        note_error($sformatf("row %0d word %0d data %h, expected %h",
          r, k, obs_data[k], exp_data[k]));
      end
      if (obs_last[k] !== exp_last[k]) begin
        note_error($sformatf("row %0d word %0d last %b, expected %b",
          r, k, obs_last[k], exp_last[k]));
      end
    end
    // same data with different timing gives the same output
    if (rows[r].replay != 0) begin
      checks++;
      if (prev_obs.size() != obs_data.size()) begin
        note_error($sformatf("row %0d gives %0d words, previous row gave %0d",
          r, obs_data.size(), prev_obs.size()));
      end else begin
        foreach (prev_obs[k]) begin
          if (obs_data[k] !== prev_obs[k]) begin
            note_error($sformatf("row %0d word %0d differs from previous row", r, k));
          end
        end
      end
    end
  endtask

  // nothing may follow the final word of a row
  task automatic check_idle(input int r);
    repeat (4) begin
      #SAMPLE;
      checks++;
      if (out_valid) begin
        note_error($sformatf("row %0d extra output word %h after packet end", r, out_data));
      end
      @(negedge clk);
    end
  endtask

  initial begin
    logic [31:0] prev_seed;
    int          total;
    reset = 1'b1;
    in_data = '0;
    in_valid = 1'b0;
    in_last = 1'b0;
    out_ready = 1'b0;
    data_state = 32'd42;
    gap_state = 32'd42;
    rdy_state = 32'd42;
    prev_seed = 32'd42;
    errors = 0;
    checks = 0;
    row_done = 1'b0;

    // len, packets, gap mode, ready mode, replay, output words per packet
    rows[0] = '{4, 1, GAP_NONE, RDY_ALWAYS, 0, 3};
    rows[1] = '{8, 1, GAP_NONE, RDY_ALWAYS, 0, 6};
    rows[2] = '{1, 1, GAP_NONE, RDY_ALWAYS, 0, 3};
    rows[3] = '{5, 1, GAP_NONE, RDY_ALWAYS, 0, 6};
    rows[4] = '{7, 1, GAP_NONE, RDY_ALWAYS, 0, 6};
    rows[5] = '{12, 1, GAP_NONE, RDY_RAND, 0, 9};
    rows[6] = '{9, 1, GAP_NONE, RDY_HOLD, 0, 9};
    rows[7] = '{9, 1, GAP_RAND, RDY_ALWAYS, 1, 9};
    rows[8] = '{6, 3, GAP_NONE, RDY_ALWAYS, 0, 6};
    rows[9] = '{3, 3, GAP_RAND, RDY_RAND, 0, 3};

    total = 0;
    foreach (rows[r]) begin
      total += rows[r].len * rows[r].npkt;
    end
    cycle_limit = 40 * total + 200;

    repeat (5) @(negedge clk);
    reset = 1'b0;
    #SAMPLE;
    checks += 2;
    if (in_ready !== 1'b1) begin
      note_error("in_ready is not high after reset");
    end
    if (out_valid !== 1'b0) begin
      note_error("out_valid is not low after reset");
    end

    for (int r = 0; r < NROWS; r++) begin
      if (rows[r].replay != 0) begin
        data_state = prev_seed;
      end
      prev_seed = data_state;
      stim_data.delete();
      stim_last.delete();
      exp_data.delete();
      exp_last.delete();
      obs_data.delete();
      obs_last.delete();
      for (int p = 0; p < rows[r].npkt; p++) begin
        make_packet(rows[r].len);
      end
      row_done = 1'b0;
      fork
        send_words(rows[r].gap);
        drive_ready(rows[r].rdy);
        collect_words(exp_data.size());
      join
      check_row(r);
      check_idle(r);
      prev_obs = obs_data;
    end

    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== files.f ====
common/resize_pkg.sv
width_converter/axis_upsizer.sv
width_converter/axis_downsizer.sv
width_converter/axis_width_converter.sv
dv/axis_width_converter_properties.sv
dv/axis_width_converter_tb.sv

// ==== Makefile ====
# Verilator build and run for the stream width converter

TOP = axis_width_converter_tb

.PHONY: all compile run clean

all: run

# build the simulation binary from the file list
compile:
	verilator --binary --timing --assert -f files.f \
		--top-module $(TOP) -Mdir obj_dir

# run the simulation, the log must hold the pass line
run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^sim passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
